/* sim.f */
src/rnn_pkg.sv
src/weight_memory.sv
src/step_sequencer.sv
src/mac_unit.sv
src/hidden_state.sv
src/rnn_cell.sv
verification/rnn_cell_sva.sv
verification/rnn_cell_tb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = rnn_cell_tb
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = tests failed
PASS_MSG   = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/rnn_cell_tb.sv */
`timescale 1ns/1ps

module rnn_cell_tb;
    import rnn_pkg::*;

    localparam int seq_len        = 20;
    localparam int total_steps    = 2 * seq_len + 4;
    localparam int load_cycles    = 3 * mem_depth * 2;     // two words of time per load
    localparam int timeout_cycles = total_steps * 200 + load_cycles + 100;

    logic                          clk;
    logic                          reset;
    logic                          load_en;
    logic [addr_width-1:0]         load_addr;
    logic [word_width-1:0]         load_data;
    logic [token_width-1:0]        token;
    logic                          step;
    logic                          clear_state;
    logic [hidden_index_width-1:0] probe_index;
    logic                          busy;
    logic                          done;
    logic [word_width-1:0]         probe_value;

    integer                 seed;
    logic [token_width-1:0] tok;
    logic [word_width-1:0]  mem_model    [mem_depth];
    logic [word_width-1:0]  hidden_model [hidden_size];
    logic [token_width-1:0] tokens       [seq_len];
    logic [word_width-1:0]  history      [seq_len][hidden_size];

    rnn_cell rnn_cell_i (
        .clk         (clk),
        .reset       (reset),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .token       (token),
        .step        (step),
        .clear_state (clear_state),
        .probe_index (probe_index),
        .busy        (busy),
        .done        (done),
        .probe_value (probe_value)
    );

    bind rnn_cell rnn_cell_sva rnn_cell_sva_i (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .busy  (busy),
        .done  (done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // checking and reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name,
                     expected, actual);
            $display("tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // bias*one + weights*operands, >>> frac_bits, clip, relu
    task automatic model_step(input logic [token_width-1:0] t);
        logic signed [acc_width-1:0] sum;
        logic signed [acc_width-1:0] w;
        logic signed [acc_width-1:0] x;
        logic signed [acc_width-1:0] shifted;
        logic [word_width-1:0]       next [hidden_size];
        for (int n = 0; n < hidden_size; n++)
        begin
            w   = $signed(mem_model[bias_base + n]);
            sum = w * fixed_one;
            for (int i = 0; i < embed_size; i++)
            begin
                w   = $signed(mem_model[w_ih_base + n * embed_size + i]);
                x   = $signed(mem_model[embed_base + t * embed_size + i]);
                sum = sum + w * x;
            end
            for (int j = 0; j < hidden_size; j++)
            begin
                w   = $signed(mem_model[w_hh_base + n * hidden_size + j]);
                x   = $signed(hidden_model[j]);     // never negative after relu
                sum = sum + w * x;
            end
            shifted = sum >>> frac_bits;
            if (shifted < 0)
                next[n] = '0;
            else if (shifted > (2 ** (word_width - 1)) - 1)
                next[n] = 16'h7fff;
            else
                next[n] = shifted[word_width-1:0];
        end
        for (int n = 0; n < hidden_size; n++)
        begin
            hidden_model[n] = next[n];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // host side drivers, all on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic write_word(input int addr, input logic [word_width-1:0] data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = addr_width'(addr);
        load_data = data;
        mem_model[addr] = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic load_small_weights();
        for (int a = 0; a < mem_depth; a++)
        begin
            if (a < w_ih_base)
                write_word(a, 16'($random(seed) % 1024));   // embeddings up to +-4.0
            else
                write_word(a, 16'($random(seed) % 128));    // weights up to +-0.5
        end
    endtask

    // even neurons pushed far positive, odd neurons far negative
    task automatic load_large_weights();
        for (int a = 0; a < mem_depth; a++)
        begin
            if (a < w_ih_base)
                write_word(a, 16'h4000);
            else if (a < w_hh_base)
                write_word(a, (((a - w_ih_base) / embed_size) % 2 == 0) ? 16'h4000 : 16'hc000);
            else
                write_word(a, 16'h0000);
        end
    endtask

    task automatic wait_done();
        do
            @(negedge clk);
        while (done !== 1'b1);
        check_value("busy", 32'd0, 32'(busy));
    endtask

    task automatic run_step(input logic [token_width-1:0] t);
        @(negedge clk);
        token = t;
        step  = 1'b1;
        @(negedge clk);
        step = 1'b0;
        check_value("busy", 32'd1, 32'(busy));
        wait_done();
    endtask

    task automatic clear_hidden();
        @(negedge clk);
        clear_state = 1'b1;
        @(negedge clk);
        clear_state = 1'b0;
        for (int i = 0; i < hidden_size; i++)
        begin
            hidden_model[i] = '0;
        end
    endtask

    task automatic check_state();
        for (int i = 0; i < hidden_size; i++)
        begin
            @(negedge clk);
            probe_index = hidden_index_width'(i);
            #1;
            check_value($sformatf("probe_value[%0d]", i), 32'(hidden_model[i]),
                        32'(probe_value));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        seed        = 32'h7631;
        reset       = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        token       = '0;
        step        = 1'b0;
        clear_state = 1'b0;
        probe_index = '0;
        for (int i = 0; i < hidden_size; i++)
        begin
            hidden_model[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset state
        check_value("busy", 32'd0, 32'(busy));
        check_state();

        // random weights, a run of random tokens
        load_small_weights();
        for (int s = 0; s < seq_len; s++)
        begin
            tokens[s] = token_width'($random(seed));
            model_step(tokens[s]);
            run_step(tokens[s]);
            check_state();
            for (int i = 0; i < hidden_size; i++)
            begin
                history[s][i] = hidden_model[i];
            end
        end

        // cleared state replays the same trajectory
        clear_hidden();
        check_state();
        for (int s = 0; s < seq_len; s++)
        begin
            model_step(tokens[s]);
            run_step(tokens[s]);
            for (int i = 0; i < hidden_size; i++)
            begin
                @(negedge clk);
                probe_index = hidden_index_width'(i);
                #1;
                check_value($sformatf("probe_value[%0d] replay", i), 32'(history[s][i]),
                            32'(probe_value));
            end
        end

        // host commands in the middle of a step
        tok = token_width'($random(seed));
        model_step(tok);
        @(negedge clk);
        token = tok;
        step  = 1'b1;
        @(negedge clk);
        step = 1'b0;
        repeat (10) @(negedge clk);
        token     = tok + 4'd1;
        step      = 1'b1;
        load_en   = 1'b1;
        load_addr = addr_width'(bias_base + hidden_size - 1);   // bias read comes later
        load_data = 16'h7fff;
        @(negedge clk);
        step    = 1'b0;
        load_en = 1'b0;
        wait_done();
        check_state();
        repeat (3) @(negedge clk);
        check_value("busy", 32'd0, 32'(busy));      // the extra pulse started nothing
        tok = token_width'($random(seed));
        model_step(tok);
        run_step(tok);
        check_state();

        // saturation and relu
        load_large_weights();
        clear_hidden();
        tok = token_width'($random(seed));
        model_step(tok);
        run_step(tok);
        check_state();
        for (int i = 0; i < hidden_size; i++)
        begin
            @(negedge clk);
            probe_index = hidden_index_width'(i);
            #1;
            check_value($sformatf("probe_value[%0d] limit", i),
                        (i % 2 == 0) ? 32'h7fff : 32'h0, 32'(probe_value));
        end

        if (rnn_cell_i.rnn_cell_sva_i.fail_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("%0d assertion failures", rnn_cell_i.rnn_cell_sva_i.fail_count);
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, a step never finished", timeout_cycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* verification/rnn_cell_sva.sv */
`timescale 1ns/1ps

module rnn_cell_sva (
    input logic clk,
    input logic reset,
    input logic step,
    input logic busy,
    input logic done
);

    int fail_count = 0;     // read by the testbench at the end of the run

    // done is a single cycle pulse
    done_one_cycle : assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    )
    else
    begin
        fail_count++;
        $error("done high for two cycles in a row");
    end

    // busy drops in the done cycle and in no other
    busy_falls_with_done : assert property (
        @(posedge clk) disable iff (reset) $fell(busy) == done
    )
    else
    begin
        fail_count++;
        $error("busy fell without done, or done without busy falling");
    end

    // an accepted step starts work on the next cycle
    step_starts_busy : assert property (
        @(posedge clk) disable iff (reset) (step && !busy) |=> busy
    )
    else
    begin
        fail_count++;
        $error("step taken while idle but busy did not rise");
    end

endmodule

/* src/rnn_cell.sv */
`timescale 1ns/1ps

module rnn_cell (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   load_en,
    input  logic [rnn_pkg::addr_width-1:0]         load_addr,
    input  logic [rnn_pkg::word_width-1:0]         load_data,
    input  logic [rnn_pkg::token_width-1:0]        token,
    input  logic                                   step,
    input  logic                                   clear_state,
    input  logic [rnn_pkg::hidden_index_width-1:0] probe_index,
    output logic                                   busy,
    output logic                                   done,
    output logic [rnn_pkg::word_width-1:0]         probe_value
);
    import rnn_pkg::*;

    logic                          rd_en;
    logic [addr_width-1:0]         rd_addr;
    logic [word_width-1:0]         rd_data;
    logic                          data_valid;
    logic [role_width-1:0]         data_role;
    logic [hidden_index_width-1:0] data_index;
    logic                          neuron_last;
    logic                          step_commit;
    logic [word_width-1:0]         operand;
    logic                          mac_valid;
    logic                          mac_first;
    logic                          mac_last;
    logic                          result_valid;
    logic [word_width-1:0]         result;

    // embedding words only fill the register, the rest go to the MAC
    assign mac_valid = data_valid && (data_role != role_embed);
    assign mac_first = data_valid && (data_role == role_bias);
    assign mac_last  = data_valid && neuron_last;

    weight_memory weight_memory_i (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .busy      (busy),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    step_sequencer step_sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .step        (step),
        .token       (token),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .busy        (busy),
        .done        (done),
        .data_valid  (data_valid),
        .data_role   (data_role),
        .data_index  (data_index),
        .neuron_last (neuron_last),
        .step_commit (step_commit)
    );

    mac_unit mac_unit_i (
        .clk          (clk),
        .reset        (reset),
        .mac_valid    (mac_valid),
        .mac_first    (mac_first),
        .mac_last     (mac_last),
        .weight       (rd_data),
        .operand      (operand),
        .result_valid (result_valid),
        .result       (result)
    );

    hidden_state hidden_state_i (
        .clk          (clk),
        .reset        (reset),
        .clear_state  (clear_state),
        .busy         (busy),
        .data_valid   (data_valid),
        .data_role    (data_role),
        .data_index   (data_index),
        .rd_data      (rd_data),
        .result_valid (result_valid),
        .result       (result),
        .probe_index  (probe_index),
        .operand      (operand),
        .step_commit  (step_commit),
        .probe_value  (probe_value)
    );

endmodule

/* src/hidden_state.sv */
`timescale 1ns/1ps

module hidden_state (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   clear_state,
    input  logic                                   busy,
    input  logic                                   data_valid,
    input  logic [rnn_pkg::role_width-1:0]         data_role,
    input  logic [rnn_pkg::hidden_index_width-1:0] data_index,
    input  logic [rnn_pkg::word_width-1:0]         rd_data,
    input  logic                                   result_valid,
    input  logic [rnn_pkg::word_width-1:0]         result,
    input  logic [rnn_pkg::hidden_index_width-1:0] probe_index,
    output logic [rnn_pkg::word_width-1:0]         operand,
    output logic                                   step_commit,
    output logic [rnn_pkg::word_width-1:0]         probe_value
);
    import rnn_pkg::*;

    logic [word_width-1:0]         embed_reg  [embed_size];
    logic [word_width-1:0]         old_hidden [hidden_size];  // committed state
    logic [word_width-1:0]         new_hidden [hidden_size];  // being built
    logic [hidden_index_width-1:0] write_index;

    assign probe_value = old_hidden[probe_index];

    ////////////////////////////////////////////////////////////////////////////
    // operand that goes with the weight on rd_data
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (data_role)
            role_bias:      operand = word_width'(fixed_one);
            role_input:     operand = embed_reg[data_index[$clog2(embed_size)-1:0]];
            role_recurrent: operand = old_hidden[data_index];
            default:        operand = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (data_valid && data_role == role_embed)
        begin
            embed_reg[data_index[$clog2(embed_size)-1:0]] <= rd_data;
        end
        if (result_valid)
        begin
            new_hidden[write_index] <= result;
        end
    end

    // results come back in neuron order
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            write_index <= '0;
            step_commit <= 1'b0;
            for (int i = 0; i < hidden_size; i++)
            begin
                old_hidden[i] <= '0;
            end
        end
        else
        begin
            step_commit <= result_valid && (write_index == hidden_index_width'(hidden_size - 1));
            if (result_valid)
            begin
                write_index <= write_index + 1'b1;  // wraps to 0 after neuron 7
            end
            if (step_commit)
            begin
                for (int i = 0; i < hidden_size; i++)
                begin
                    old_hidden[i] <= new_hidden[i];
                end
            end
            else if (clear_state && !busy)
            begin
                for (int i = 0; i < hidden_size; i++)
                begin
                    old_hidden[i] <= '0;
                end
            end
        end
    end

endmodule

/* src/mac_unit.sv */
`timescale 1ns/1ps

module mac_unit (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  mac_valid,
    input  logic                                  mac_first,
    input  logic                                  mac_last,
    input  logic signed [rnn_pkg::word_width-1:0] weight,
    input  logic signed [rnn_pkg::word_width-1:0] operand,
    output logic                                  result_valid,
    output logic        [rnn_pkg::word_width-1:0] result
);
    import rnn_pkg::*;

    logic signed [acc_width-1:0] product;
    logic signed [acc_width-1:0] acc;
    logic signed [acc_width-1:0] sum;
    logic signed [acc_width-1:0] shifted;
    logic                        prod_valid;
    logic                        prod_first;
    logic                        prod_last;

    // bias word restarts the running sum
    assign sum     = prod_first ? product : acc + product;
    assign shifted = sum >>> frac_bits;     // back to Q8.8

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prod_valid   <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            prod_valid   <= mac_valid;
            result_valid <= prod_valid && prod_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // product stage, then accumulate and requantize
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        product    <= weight * operand;     // full 32 bit product
        prod_first <= mac_first;
        prod_last  <= mac_last;
        if (prod_valid)
        begin
            acc <= sum;
        end
        if (prod_valid && prod_last)
        begin
            if (shifted < 0)
            begin
                result <= '0;               // relu
            end
            else if (shifted > (2 ** (word_width - 1)) - 1)
            begin
                result <= {1'b0, {(word_width - 1){1'b1}}};   // clip at +127.996
            end
            else
            begin
                result <= shifted[word_width-1:0];
            end
        end
    end

endmodule

/* src/step_sequencer.sv */
`timescale 1ns/1ps

module step_sequencer (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   step,
    input  logic [rnn_pkg::token_width-1:0]        token,
    output logic                                   rd_en,
    output logic [rnn_pkg::addr_width-1:0]         rd_addr,
    output logic                                   busy,
    output logic                                   done,
    output logic                                   data_valid,
    output logic [rnn_pkg::role_width-1:0]         data_role,
    output logic [rnn_pkg::hidden_index_width-1:0] data_index,
    output logic                                   neuron_last,
    input  logic                                   step_commit
);
    import rnn_pkg::*;

    localparam logic [1:0] s_idle   = 2'd0;
    localparam logic [1:0] s_embed  = 2'd1;
    localparam logic [1:0] s_neuron = 2'd2;
    localparam logic [1:0] s_finish = 2'd3;

    logic [1:0]                    state;
    logic [3:0]                    elem_count;    // 0 bias, 1..4 input, 5..12 recurrent
    logic [hidden_index_width-1:0] neuron_count;
    logic [token_width-1:0]        token_q;

    logic [role_width-1:0]         cur_role;
    logic [hidden_index_width-1:0] cur_index;
    logic                          cur_last;

    assign busy = (state != s_idle);

    ////////////////////////////////////////////////////////////////////////////
    // address and role of the read issued this cycle
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        rd_en     = 1'b0;
        rd_addr   = '0;
        cur_role  = role_embed;
        cur_index = '0;
        cur_last  = 1'b0;
        case (state)
            s_embed:
            begin
                rd_en     = 1'b1;
                rd_addr   = addr_width'(embed_base + token_q * embed_size + elem_count);
                cur_index = hidden_index_width'(elem_count);
            end
            s_neuron:
            begin
                rd_en = 1'b1;
                if (elem_count == 4'd0)
                begin
                    cur_role = role_bias;
                    rd_addr  = addr_width'(bias_base + neuron_count);
                end
                else if (elem_count <= 4'(embed_size))
                begin
                    cur_role  = role_input;
                    cur_index = hidden_index_width'(elem_count - 4'd1);
                    rd_addr   = addr_width'(w_ih_base + neuron_count * embed_size
                                            + elem_count - 1);
                end
                else
                begin
                    cur_role  = role_recurrent;
                    cur_index = hidden_index_width'(elem_count - 4'(1 + embed_size));
                    rd_addr   = addr_width'(w_hh_base + neuron_count * hidden_size
                                            + elem_count - 1 - embed_size);
                    cur_last  = (elem_count == 4'(embed_size + hidden_size));
                end
            end
            default:
            begin
                rd_en = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= s_idle;
            elem_count   <= '0;
            neuron_count <= '0;
            done         <= 1'b0;
            data_valid   <= 1'b0;
        end
        else
        begin
            done       <= 1'b0;
            data_valid <= rd_en;    // memory answers next cycle
            case (state)
                s_idle:
                begin
                    if (step)
                    begin
                        elem_count   <= '0;
                        neuron_count <= '0;
                        state        <= s_embed;
                    end
                end
                s_embed:
                begin
                    if (elem_count == 4'(embed_size - 1))
                    begin
                        elem_count <= '0;
                        state      <= s_neuron;
                    end
                    else
                    begin
                        elem_count <= elem_count + 4'd1;
                    end
                end
                s_neuron:
                begin
                    if (elem_count == 4'(embed_size + hidden_size))
                    begin
                        elem_count   <= '0;
                        neuron_count <= neuron_count + 1'b1;
                        if (neuron_count == hidden_index_width'(hidden_size - 1))
                        begin
                            state <= s_finish;  // last reads in flight
                        end
                    end
                    else
                    begin
                        elem_count <= elem_count + 4'd1;
                    end
                end
                default:
                begin
                    if (step_commit)
                    begin
                        state <= s_idle;
                        done  <= 1'b1;      // same cycle busy drops
                    end
                end
            endcase
        end
    end

    // tags travel one cycle behind the address, token held for the step
    always_ff @(posedge clk)
    begin
        data_role   <= cur_role;
        data_index  <= cur_index;
        neuron_last <= cur_last;
        if (state == s_idle && step)
        begin
            token_q <= token;
        end
    end

endmodule

/* src/weight_memory.sv */
`timescale 1ns/1ps

module weight_memory (
    input  logic                           clk,
    input  logic                           load_en,
    input  logic [rnn_pkg::addr_width-1:0] load_addr,
    input  logic [rnn_pkg::word_width-1:0] load_data,
    input  logic                           busy,
    input  logic                           rd_en,
    input  logic [rnn_pkg::addr_width-1:0] rd_addr,
    output logic [rnn_pkg::word_width-1:0] rd_data
);
    import rnn_pkg::*;

    logic [word_width-1:0] mem [mem_depth];

    // host side, only between steps
    always_ff @(posedge clk)
    begin
        if (load_en && !busy && load_addr < addr_width'(mem_depth))
        begin
            mem[load_addr] <= load_data;
        end
    end

    // sequencer side, data one cycle after rd_en
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* src/rnn_pkg.sv */
package rnn_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // network sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int vocab_size         = 16;
    localparam int embed_size         = 4;
    localparam int hidden_size        = 8;
    localparam int token_width        = 4;
    localparam int hidden_index_width = 3;

    // signed Q8.8 values, 32 bit sums
    localparam int word_width = 16;
    localparam int frac_bits  = 8;
    localparam int acc_width  = 32;
    localparam int fixed_one  = 256;        // 1.0 in Q8.8

    ////////////////////////////////////////////////////////////////////////////
    // parameter memory map, one word per address
    ////////////////////////////////////////////////////////////////////////////
    localparam int embed_base = 0;          // token-major, 16 x 4
    localparam int w_ih_base  = 64;         // neuron-major, 8 x 4
    localparam int w_hh_base  = 96;         // neuron-major, 8 x 8
    localparam int bias_base  = 160;        // one per neuron
    localparam int mem_depth  = 168;
    localparam int addr_width = 8;

    // what a word coming back from memory is used for
    localparam int role_width = 2;
    localparam logic [role_width-1:0] role_embed     = 2'd0;
    localparam logic [role_width-1:0] role_bias      = 2'd1;
    localparam logic [role_width-1:0] role_input     = 2'd2;
    localparam logic [role_width-1:0] role_recurrent = 2'd3;

endpackage
